// File: hw/cart_loader_top.sv
//////////////////////////////////////////////////////////////////////
// Cartridge loader top level
// Host must honor load_wait and leave a gap cycle between strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "nes_loader_defines.svh"

module cart_loader_top (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    download,
	input  logic [7:0]              file_type,
	input  logic [7:0]              file_byte,
	input  logic                    file_strobe,
	input  logic                    invert_mirroring,
	input  logic                    mem_slot,
	output logic                    load_wait,
	output cart_pkg::mem_write_t    mem,
	output cart_pkg::mapper_flags_t mapper_flags,
	output logic                    busy,
	output logic                    done,
	output logic                    error,
	output cheat_pkg::cheat_code_t  cheat_code,
	output logic                    cheat_strobe
);

	import cart_pkg::*;
	import cheat_pkg::*;

	logic                  hdr_we;
	logic                  cheat_we;
	cheat_index_t          byte_index;
	mem_write_t            wr_req;
	logic                  hdr_valid;
	logic [`LD_ADDR_W-1:0] prg_bytes;
	logic [`LD_ADDR_W-1:0] chr_bytes;

	load_sequencer u_seq (
		.clk         (clk),
		.reset_nes   (reset_nes),
		.download    (download),
		.file_type   (file_type),
		.file_byte   (file_byte),
		.file_strobe (file_strobe),
		.hdr_valid   (hdr_valid),
		.prg_bytes   (prg_bytes),
		.chr_bytes   (chr_bytes),
		.hdr_we      (hdr_we),
		.byte_index  (byte_index),
		.cheat_we    (cheat_we),
		.wr_req      (wr_req),
		.busy        (busy),
		.done        (done),
		.error       (error)
	);

	ines_header u_hdr (
		.clk              (clk),
		.hdr_we           (hdr_we),
		.byte_index       (byte_index),
		.file_byte        (file_byte),
		.invert_mirroring (invert_mirroring),
		.hdr_valid        (hdr_valid),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.flags            (mapper_flags)
	);

	write_slot u_slot (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wr_req    (wr_req),
		.mem_slot  (mem_slot),
		.mem       (mem),
		.load_wait (load_wait)
	);

	cheat_assembler u_cheat (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.cheat_we     (cheat_we),
		.byte_index   (byte_index),
		.file_byte    (file_byte),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe)
	);

endmodule

`default_nettype wire

// File: hw/cart_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types of the cartridge loading path
// mapper_flags_t bit layout is what the console core expects
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "nes_loader_defines.svh"

package cart_pkg;

	typedef enum logic [2:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_ERROR,
		ST_DONE
	} loader_state_t;

	typedef enum logic {
		FK_GAME,
		FK_CHEAT
	} file_kind_t;

	// Decoded header as handed to the mapper logic
	typedef struct packed {
		logic [5:0] pad;
		logic       has_saves;
		logic [7:0] submapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic [`LD_ADDR_W-1:0] addr;
		logic [7:0]            data;
		logic                  wr;
	} mem_write_t;

endpackage

`default_nettype wire

// File: hw/cheat_assembler.sv
//////////////////////////////////////////////////////////////////////
// Packs a 16 byte cheat record, little endian within each field
// cheat_code holds the last record until the next one completes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module cheat_assembler (
	input  logic                    clk,
	input  logic                    reset_nes,
	input  logic                    cheat_we,
	input  cheat_pkg::cheat_index_t byte_index,
	input  logic [7:0]              file_byte,
	output cheat_pkg::cheat_code_t  cheat_code,
	output logic                    cheat_strobe
);

	logic [6:0] bit_pos;

	// Field 0 (flags) is the top word, lane 0 its low byte
	assign bit_pos = {~byte_index[3:2], byte_index[1:0], 3'b000};

	always_ff @(posedge clk) begin
		if (cheat_we)
			cheat_code[bit_pos +: 8] <= file_byte;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= cheat_we && (byte_index == 4'd15);   // Record complete
	end

endmodule

`default_nettype wire

// File: hw/cheat_pkg.sv
//////////////////////////////////////////////////////////////////////
// Cheat record types, one record is 16 bytes on the host side
//////////////////////////////////////////////////////////////////////

`default_nettype none

package cheat_pkg;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef logic [3:0] cheat_index_t;     // Byte position inside a record

endpackage

`default_nettype wire

// File: hw/ines_header.sv
//////////////////////////////////////////////////////////////////////
// iNES header capture and decode
// Outputs are combinational from the stored bytes, so they are only
// meaningful once all 16 header bytes have been written
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "nes_loader_defines.svh"

module ines_header (
	input  logic                  clk,
	input  logic                  hdr_we,
	input  cheat_pkg::cheat_index_t byte_index,
	input  logic [7:0]            file_byte,
	input  logic                  invert_mirroring,
	output logic                  hdr_valid,
	output logic [`LD_ADDR_W-1:0] prg_bytes,
	output logic [`LD_ADDR_W-1:0] chr_bytes,
	output cart_pkg::mapper_flags_t flags
);

	logic [7:0] hdr [0:`LD_HDR_LEN-1];
	logic       is_nes20;
	logic       is_dirty;
	logic [7:0] prg_pages;
	logic [7:0] chr_pages;

	// Log2 style size code, saturates at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (8'd1 << i))
				code = i[2:0];
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (hdr_we)
			hdr[byte_index] <= file_byte;
	end

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];    // Zero means CHR RAM on the cart

	// Trainers are not supported
	assign hdr_valid = (hdr[0] == `LD_MAGIC0) && (hdr[1] == `LD_MAGIC1) &&
		(hdr[2] == `LD_MAGIC2) && (hdr[3] == `LD_MAGIC3) && !hdr[6][2];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != 7'd0) ||
		(hdr[10] != 8'd0) || (hdr[11] != 8'd0) || (hdr[12] != 8'd0) ||
		(hdr[13] != 8'd0) || (hdr[14] != 8'd0) || (hdr[15] != 8'd0));

	assign prg_bytes = {{(`LD_ADDR_W-8){1'b0}}, prg_pages} << `LD_PRG_SHIFT;
	assign chr_bytes = {{(`LD_ADDR_W-8){1'b0}}, chr_pages} << `LD_CHR_SHIFT;

	assign flags = '{
		pad:         6'd0,
		has_saves:   hdr[6][1],
		submapper:   is_nes20 ? hdr[8] : 8'h00,
		four_screen: hdr[6][3],
		chr_ram:     (chr_pages == 8'd0),
		mirroring:   hdr[6][0] ^ invert_mirroring,
		chr_size:    size_code(chr_pages),
		prg_size:    size_code(prg_pages),
		mapper:      {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]}
	};

endmodule

`default_nettype wire

// File: hw/load_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Loader control FSM and address generation
// Host must raise download at least one cycle before the first strobe
// A cheat file may hold several 16 byte records back to back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "nes_loader_defines.svh"

module load_sequencer (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  download,
	input  logic [7:0]            file_type,
	input  logic [7:0]            file_byte,
	input  logic                  file_strobe,
	input  logic                  hdr_valid,
	input  logic [`LD_ADDR_W-1:0] prg_bytes,
	input  logic [`LD_ADDR_W-1:0] chr_bytes,
	output logic                  hdr_we,
	output cheat_pkg::cheat_index_t byte_index,
	output logic                  cheat_we,
	output cart_pkg::mem_write_t  wr_req,
	output logic                  busy,
	output logic                  done,
	output logic                  error
);

	import cart_pkg::*;
	import cheat_pkg::*;

	loader_state_t         state;
	file_kind_t            kind;
	cheat_index_t          idx;
	logic [`LD_ADDR_W-1:0] bytes_left;
	logic [`LD_ADDR_W-1:0] addr;
	logic                  download_d;
	logic                  take;
	logic                  in_payload;

	assign take       = file_strobe && download && download_d;
	assign in_payload = (state == ST_PRG) || (state == ST_CHR);

	assign hdr_we     = take && (state == ST_HEADER) && (kind == FK_GAME);
	assign cheat_we   = take && (state == ST_HEADER) && (kind == FK_CHEAT);
	assign byte_index = idx;
	assign wr_req     = '{addr: addr, data: file_byte, wr: take && in_payload};

	assign busy  = in_payload;
	assign done  = (state == ST_DONE);
	assign error = (state == ST_ERROR);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= ST_HEADER;
			kind       <= FK_GAME;
			idx        <= '0;
			bytes_left <= '0;
			addr       <= '0;
			download_d <= 1'b0;
		end else begin
			download_d <= download;
			if (download && !download_d) begin    // New file
				kind  <= (file_type == `LD_CHEAT_TYPE) ? FK_CHEAT : FK_GAME;
				state <= ST_HEADER;
				idx   <= '0;
			end else if (take) begin
				case (state)
				ST_HEADER: begin
					idx <= idx + 1'd1;
					if (kind == FK_GAME && idx == cheat_index_t'(`LD_HDR_LEN - 1)) begin
						if (!hdr_valid) begin
							state <= ST_ERROR;
						end else if (prg_bytes != '0) begin
							state      <= ST_PRG;
							addr       <= '0;
							bytes_left <= prg_bytes;
						end else if (chr_bytes != '0) begin
							state      <= ST_CHR;
							addr       <= `LD_CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state <= ST_DONE;
						end
					end
				end
				ST_PRG, ST_CHR: begin
					addr       <= addr + 1'd1;
					bytes_left <= bytes_left - 1'd1;
					if (bytes_left == `LD_ADDR_W'(1)) begin
						// No CHR pages means the cart has CHR RAM
						if (state == ST_PRG && chr_bytes != '0) begin
							state      <= ST_CHR;
							addr       <= `LD_CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state <= ST_DONE;
						end
					end
				end
				default: ;                            // Wait for the next file
				endcase
			end
		end
	end

	// PRG writes stay below the CHR base, CHR writes at or above it
	a_wr_in_payload: assert property (@(posedge clk) disable iff (reset_nes)
		wr_req.wr |-> (state == ST_PRG && addr < `LD_CHR_BASE) ||
			(state == ST_CHR && addr >= `LD_CHR_BASE));

endmodule

`default_nettype wire

// File: hw/nes_loader_defines.svh
//////////////////////////////////////////////////////////////////////
// Loader constants shared by the RTL and the testbench
// Addresses are byte addresses into one flat 4 MB cartridge memory
// CHR ROM sits in the upper half, PRG ROM starts at zero
//////////////////////////////////////////////////////////////////////

`ifndef NES_LOADER_DEFINES_SVH
`define NES_LOADER_DEFINES_SVH

`define LD_ADDR_W       22
`define LD_HDR_LEN      16
`define LD_PRG_SHIFT    14      // 16 KB PRG pages
`define LD_CHR_SHIFT    13      // 8 KB CHR pages
`define LD_CHR_BASE     22'h200000

// iNES signature "NES" followed by EOF
`define LD_MAGIC0       8'h4E
`define LD_MAGIC1       8'h45
`define LD_MAGIC2       8'h53
`define LD_MAGIC3       8'h1A

`define LD_CHEAT_TYPE   8'hFF

`endif

// File: hw/write_slot.sv
//////////////////////////////////////////////////////////////////////
// One entry write buffer aligned to the memory time slot
// mem_slot is a single cycle pulse from the console clock divider
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module write_slot (
	input  logic                 clk,
	input  logic                 reset_nes,
	input  cart_pkg::mem_write_t wr_req,
	input  logic                 mem_slot,
	output cart_pkg::mem_write_t mem,
	output logic                 load_wait
);

	import cart_pkg::*;

	mem_write_t held;      // Address and data only, wr unused
	logic       pending;
	logic       mem_wr;

	always_ff @(posedge clk) begin
		if (wr_req.wr)
			held <= wr_req;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending   <= 1'b0;
			mem_wr    <= 1'b0;
			load_wait <= 1'b0;
		end else begin
			if (wr_req.wr) begin
				pending   <= 1'b1;
				load_wait <= 1'b1;
			end
			if (mem_slot) begin
				mem_wr <= pending;              // Held for one full slot
				if (pending)
					pending <= 1'b0;
				else if (mem_wr)
					load_wait <= 1'b0;          // Slot done, release host
			end
		end
	end

	assign mem = '{addr: held.addr, data: held.data, wr: mem_wr};

	// Host back-pressure must keep the buffer from overflowing
	a_no_overrun: assert property (@(posedge clk) disable iff (reset_nes)
		wr_req.wr |-> !pending && !mem_wr && !load_wait);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the loader testbench, exit status is the result
verilator --binary --timing --assert -f sim.f --top-module tb_cart_loader -o tb_cart_loader \
	&& ./obj_dir/tb_cart_loader \
	|| exit 1

// File: sim.f
+incdir+hw
hw/cart_pkg.sv
hw/cheat_pkg.sv
hw/ines_header.sv
hw/load_sequencer.sv
hw/write_slot.sv
hw/cheat_assembler.sv
hw/cart_loader_top.sv
tests/tb_cart_loader.sv

// File: tests/load_trace.txt
# Kind (R game, C cheat), 16 header or cheat bytes in hex,
# expected mapper flags in hex, expected error bit
R 4E 45 53 1A 01 01 11 00 00 00 00 00 00 00 00 00 00004001 0
R 4E 45 53 1A 03 00 22 40 00 00 00 00 00 00 00 00 02008242 0
R 4E 45 53 1A 01 02 41 30 00 00 55 00 00 00 00 00 00004804 0
R 4E 45 53 1A 01 01 48 18 05 00 07 00 00 00 00 00 000B0014 0
R 4E 45 53 1B 01 01 00 00 00 00 00 00 00 00 00 00 00000000 1
R 4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00 00000000 1
C 01 00 00 00 34 12 00 00 AA 00 00 00 55 00 00 00 00000000 0
C 78 56 34 12 EF BE AD DE 11 22 33 44 99 88 77 66 00000000 0

// File: tests/tb_cart_loader.sv
//////////////////////////////////////////////////////////////////////
// Trace driven testbench for the cartridge loader
// Header lines come from tests/load_trace.txt, payload bytes are random
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "nes_loader_defines.svh"

module tb_cart_loader;

	import cart_pkg::*;
	import cheat_pkg::*;

	logic clk, reset_nes, download, file_strobe, invert_mirroring, mem_slot;
	logic [7:0] file_type, file_byte;
	logic load_wait, busy, done, error, cheat_strobe;
	mem_write_t mem;
	mapper_flags_t mapper_flags;
	cheat_code_t cheat_code;

	byte unsigned tr_kind[$];             // Trace columns
	logic [7:0] tr_byte[$];
	logic [31:0] tr_flags[$];
	logic tr_err[$];
	logic [`LD_ADDR_W-1:0] exp_addr_q[$];  // Reference write stream
	logic [7:0] exp_data_q[$];
	int fd, c, r, n, i, k, len, prg_len, file_writes, strobe_count;
	int unsigned cycles, limit, total;
	logic [7:0] b;
	logic [31:0] fl;
	cheat_code_t exp_cheat;
	logic mem_wr_prev;

	cart_loader_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	// Host side byte transfer, honors load_wait and leaves a gap cycle
	task automatic send_byte(input logic [7:0] value);
		@(posedge clk);
		file_byte   <= value;
		file_strobe <= 1'b1;
		@(posedge clk);
		file_strobe <= 1'b0;
		@(negedge clk);
		while (load_wait)
			@(negedge clk);
	endtask

	// Divider phase stand in, one pulse every fourth cycle
	logic [1:0] phase;
	always @(posedge clk) begin
		if (reset_nes) begin
			phase    <= 2'd0;
			mem_slot <= 1'b0;
		end else begin
			phase    <= phase + 2'd1;
			mem_slot <= (phase == 2'd3);
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("Timeout: the loader did not finish within %0d cycles", limit);
			$display("Finished with errors");
			$fatal(1);
		end
	end

	// Write and cheat strobe monitor
	always @(negedge clk) begin
		if (!reset_nes) begin
			if (mem.wr && !mem_wr_prev) begin
				if (exp_addr_q.size() == 0) begin
					$display("Unexpected memory write to address %0h", mem.addr);
					$display("Finished with errors");
					$fatal(1);
				end
				check(mem.addr, exp_addr_q.pop_front(), "write address");
				check(mem.data, exp_data_q.pop_front(), "write data");
				file_writes = file_writes + 1;
			end
			if (cheat_strobe)
				strobe_count = strobe_count + 1;
		end
		mem_wr_prev = mem.wr;
	end

	initial begin
		reset_nes        = 1'b1;
		download         = 1'b0;
		file_strobe      = 1'b0;
		invert_mirroring = 1'b0;
		mem_slot         = 1'b0;
		file_type        = 8'h00;
		file_byte        = 8'h00;
		cycles           = 0;
		limit            = 0;
		total            = 0;
		mem_wr_prev      = 1'b0;
		void'($urandom(32'h6928));
		fd = $fopen("tests/load_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tests/load_trace.txt");
			$display("Finished with errors");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			c = $fgetc(fd);
			if (c == "#") begin
				while (c != "\n" && c != -1)    // Rest of the comment line
					c = $fgetc(fd);
			end else if (c == "R" || c == "C") begin
				tr_kind.push_back(8'(c));
				r = 0;
				for (i = 0; i < 16; i++) begin
					r = r + $fscanf(fd, " %h", b);
					tr_byte.push_back(b);
				end
				r = r + $fscanf(fd, " %h %h", fl, b);
				if (r != 18) begin
					$display("Malformed record %0d in the trace file", tr_kind.size());
					$display("Finished with errors");
					$fatal(1);
				end
				tr_flags.push_back(fl);
				tr_err.push_back(b[0]);
				total = total + 16;
				if (c == "R" && !b[0])
					total = total + tr_byte[$-11] * 16384 + tr_byte[$-10] * 8192;
			end
		end
		$fclose(fd);
		limit = 10 * total + 1000;
		repeat (2) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);
		check({busy, done, error, load_wait, mem.wr, cheat_strobe}, 6'd0, "outputs after reset");

		for (n = 0; n < tr_kind.size(); n++) begin
			file_writes  = 0;
			strobe_count = 0;
			@(posedge clk);
			download  <= 1'b1;
			file_type <= (tr_kind[n] == "C") ? `LD_CHEAT_TYPE : 8'h00;
			@(posedge clk);
			for (i = 0; i < 16; i++)
				send_byte(tr_byte[16*n+i]);
			if (tr_kind[n] == "C") begin
				// Fields in record order, first byte least significant
				exp_cheat.flags   = {tr_byte[16*n+3], tr_byte[16*n+2],
					tr_byte[16*n+1], tr_byte[16*n]};
				exp_cheat.address = {tr_byte[16*n+7], tr_byte[16*n+6],
					tr_byte[16*n+5], tr_byte[16*n+4]};
				exp_cheat.compare = {tr_byte[16*n+11], tr_byte[16*n+10],
					tr_byte[16*n+9], tr_byte[16*n+8]};
				exp_cheat.replace = {tr_byte[16*n+15], tr_byte[16*n+14],
					tr_byte[16*n+13], tr_byte[16*n+12]};
				repeat (4) @(negedge clk);
				check(strobe_count, 1, "cheat strobe count");
				check(cheat_code, exp_cheat, "cheat code");
				check(file_writes, 0, "writes during cheat file");
			end else if (tr_err[n]) begin
				check(error, 1'b1, "error on bad header");
				for (k = 0; k < 4; k++)          // Bytes after a bad header are dropped
					send_byte(8'($urandom));
				check(error, 1'b1, "error held after bad header");
				check(file_writes, 0, "writes after bad header");
			end else begin
				check(busy, 1'b1, "busy after header");
				check(mapper_flags, tr_flags[n], "mapper flags");
				prg_len = tr_byte[16*n+4] * 16384;
				len     = prg_len + tr_byte[16*n+5] * 8192;
				for (k = 0; k < len; k++) begin
					b = 8'($urandom);
					exp_addr_q.push_back((k < prg_len) ? `LD_ADDR_W'(k) :
						`LD_CHR_BASE + `LD_ADDR_W'(k - prg_len));
					exp_data_q.push_back(b);
					send_byte(b);
				end
				while (!done || load_wait || mem.wr)
					@(negedge clk);
				check(file_writes, len, "write count");
			end
			@(posedge clk);
			download <= 1'b0;
			@(posedge clk);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
